/* compile.f */
rtl/corr_pkg.sv
rtl/corr_frame_if.sv
rtl/pulse_counter_bank.sv
rtl/baseline_accumulator.sv
rtl/integration_control.sv
rtl/frame_serializer.sv
rtl/correlator_top.sv
dv/correlator_tb.sv

/* dv/correlator_tb.sv */
// Correlator testbench with random samples, a frame model and a credit-returning sink.
`timescale 1ns/10ps

module correlator_tb;
	import corr_pkg::*;

	localparam int clk_period = 8;
	localparam int total_samples = 600 + 600 + 3000 + 400 + 200;
	localparam int watchdog_ns = total_samples * 4 * clk_period + 2000;
	localparam int pair_a [6] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_b [6] = '{1, 2, 3, 2, 3, 3};

	logic clk;
	logic reset;
	logic sample_valid;
	logic [num_lines-1:0] sample_bits;
	logic [integ_len_width-1:0] integ_len;
	acc_mode_e mode_in;
	logic credit_return;
	logic out_valid;
	logic [word_index_width-1:0] out_index;
	logic [resolution-1:0] out_data;
	logic overrun;

	logic [31:0] lcg_state = 32'hd600a34e;
	int m_counts [num_lines];
	int m_acc [num_baselines];
	int m_cnt;
	int m_len;
	int owed;
	int exp_index;
	int outstanding;
	int cycle;
	int accepted;
	acc_mode_e m_mode;
	logic exp_overrun;
	logic [resolution-1:0] exp_words [$];
	int due_q [$];
	int cur_len_lo;
	int cur_len_hi;
	int cur_mode_sel;
	int cur_valid_pct;
	int cur_min_delay;
	bit cur_biased;

	correlator_top correlator_top_inst (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_bits(sample_bits),
		.integ_len(integ_len),
		.mode_in(mode_in),
		.credit_return(credit_return),
		.out_valid(out_valid),
		.out_index(out_index),
		.out_data(out_data),
		.overrun(overrun)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic int next_random(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[31:8] % n); // Low bits of an LCG repeat too quickly.
	endfunction

	task automatic abort_run(input string why);
		$display("RESULT: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		abort_run(what);
	endtask

	task automatic report_mismatch(input string sig, input int expected, input int actual);
		$display("Error at %0t ns: %s expected %0h, actual %0h", $time, sig, expected, actual);
		abort_run("output mismatch");
	endtask

	// Mirrors one accepted sample and closes the frame on its last sample.
	task automatic model_sample(input logic [num_lines-1:0] b, input int len, input acc_mode_e m);
		int stepv;
		int mag;
		logic [resolution-1:0] status;
		if (m_cnt == 0) begin
			m_len = (len == 0) ? 1 : len;
			m_mode = m;
		end
		for (int i = 0; i < num_lines; i++) begin
			if (b[i] && m_counts[i] < max_pulses) m_counts[i]++;
		end
		for (int j = 0; j < num_baselines; j++) begin
			if (m_mode == acc_product) stepv = int'(b[pair_a[j]] & b[pair_b[j]]);
			else stepv = int'(b[pair_a[j]]) - int'(b[pair_b[j]]);
			mag = (m_acc[j] < 0) ? -m_acc[j] : m_acc[j];
			if (mag < acc_bound) m_acc[j] += stepv;
		end
		m_cnt++;
		accepted++;
		if (m_cnt == m_len) begin
			if (owed == 0) begin
				status = '0;
				for (int i = 0; i < num_lines; i++) begin
					exp_words.push_back(m_counts[i][resolution-1:0]);
				end
				for (int j = 0; j < num_baselines; j++) begin
					exp_words.push_back(m_acc[j][resolution-1:0]);
					status[j] = (m_acc[j] == acc_bound) || (m_acc[j] == -acc_bound);
				end
				exp_words.push_back(status);
				owed = frame_words;
			end else begin
				exp_overrun = 1'b1; // Serializer is still busy, so this frame is lost.
			end
			for (int i = 0; i < num_lines; i++) m_counts[i] = 0;
			for (int j = 0; j < num_baselines; j++) m_acc[j] = 0;
			m_cnt = 0;
		end
	endtask

	task automatic check_word(input logic [word_index_width-1:0] idx,
			input logic [resolution-1:0] data);
		int due;
		assert (exp_words.size() > 0)
			else report_failure("word received with no frame expected");
		assert (int'(idx) == exp_index) else report_mismatch("out_index", exp_index, idx);
		assert (data == exp_words[0]) else report_mismatch("out_data", exp_words[0], data);
		void'(exp_words.pop_front());
		owed--;
		exp_index = (exp_index == frame_words - 1) ? 0 : exp_index + 1;
		outstanding++;
		assert (outstanding <= num_credits)
			else report_failure("sink holds more words than credits");
		due = cycle + 1 + cur_min_delay + next_random(6 - cur_min_delay);
		if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1; // One credit per cycle.
		due_q.push_back(due);
	endtask

	task automatic step_cycle(input bit allow_valid);
		logic obs_valid;
		logic [word_index_width-1:0] obs_index;
		logic [resolution-1:0] obs_data;
		logic v;
		logic [num_lines-1:0] b;
		int len;
		acc_mode_e m;
		@(negedge clk);
		cycle++;
		assert (overrun === exp_overrun) else report_mismatch("overrun", exp_overrun, overrun);
		obs_valid = out_valid;
		obs_index = out_index;
		obs_data = out_data;
		credit_return = 1'b0;
		if (due_q.size() > 0 && due_q[0] <= cycle) begin
			void'(due_q.pop_front());
			credit_return = 1'b1;
			outstanding--;
		end
		v = allow_valid && (next_random(100) < cur_valid_pct);
		for (int i = 0; i < num_lines; i++) begin
			b[i] = cur_biased ? (next_random(8) != 0) : next_random(2);
		end
		len = cur_len_lo + next_random(cur_len_hi - cur_len_lo + 1);
		m = (cur_mode_sel == 2) ? acc_mode_e'(next_random(2)) : acc_mode_e'(cur_mode_sel);
		sample_valid = v;
		sample_bits = b;
		integ_len = integ_len_width'(len);
		mode_in = m;
		if (v) model_sample(b, len, m); // Must see owed before this cycle's word is counted.
		if (obs_valid) check_word(obs_index, obs_data);
	endtask

	task automatic run_phase(input int samples, input int len_lo, input int len_hi,
			input int mode_sel, input int valid_pct, input bit biased, input int min_delay);
		cur_len_lo = len_lo;
		cur_len_hi = len_hi;
		cur_mode_sel = mode_sel;
		cur_valid_pct = valid_pct;
		cur_biased = biased;
		cur_min_delay = min_delay;
		accepted = 0;
		while (accepted < samples || m_cnt != 0) step_cycle(1'b1);
	endtask

	initial begin
		#(watchdog_ns);
		report_failure("watchdog expired before the test finished");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		sample_valid = 1'b0;
		sample_bits = '0;
		integ_len = '0;
		mode_in = acc_product;
		credit_return = 1'b0;
		m_cnt = 0;
		owed = 0;
		exp_index = 0;
		outstanding = 0;
		cycle = 0;
		exp_overrun = 1'b0;
		for (int i = 0; i < num_lines; i++) m_counts[i] = 0;
		for (int j = 0; j < num_baselines; j++) m_acc[j] = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (out_valid === 1'b0) else report_mismatch("out_valid", 0, out_valid);
		assert (overrun === 1'b0) else report_mismatch("overrun", 0, overrun);
		reset = 1'b1;
		run_phase(600, 8, 40, 0, 75, 1'b0, 0); // Product mode with short frames.
		run_phase(600, 8, 40, 1, 75, 1'b0, 0);
		run_phase(3000, 1500, 1500, 0, 100, 1'b1, 0); // Saturation with mostly ones.
		run_phase(400, 8, 40, 2, 75, 1'b0, 4);
		run_phase(200, 0, 1, 0, 100, 1'b0, 4); // Length 0 or 1 forces overruns.
		repeat (200) step_cycle(1'b0);
		if (exp_words.size() != 0 || !overrun) begin
			report_failure("frames still owed or overrun never raised at end of test");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

/* rtl/baseline_accumulator.sv */
// Baseline accumulator with one bounded signed sum per line pair in product or difference mode.
`timescale 1ns/10ps

module baseline_accumulator (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic [corr_pkg::num_lines-1:0] sample_bits,
	input corr_pkg::acc_mode_e mode,
	corr_frame_if.src frame
);
	import corr_pkg::*;

	acc_t acc_q [num_baselines];
	acc_t acc_next [num_baselines];
	acc_t step [num_baselines];
	logic [num_baselines-1:0] at_bound;
	logic [num_baselines-1:0] next_at_bound;

	always_comb begin
		logic bit_a;
		logic bit_b;
		for (int i = 0; i < num_baselines; i++) begin
			bit_a = sample_bits[bl_first[i]];
			bit_b = sample_bits[bl_second[i]];
			if (mode == acc_product) begin
				step[i] = acc_t'(bit_a & bit_b);
			end else begin
				step[i] = acc_t'(bit_a) - acc_t'(bit_b); // Ranges from -1 to +1.
			end
		end
	end

	always_comb begin
		for (int i = 0; i < num_baselines; i++) begin
			at_bound[i] = (acc_q[i] == acc_t'(acc_bound)) || (acc_q[i] == -acc_t'(acc_bound));
			acc_next[i] = acc_q[i];
			// A sum that touched the bound is frozen for the rest of the frame.
			if (sample_valid && !at_bound[i]) begin
				acc_next[i] = acc_q[i] + step[i];
			end
			next_at_bound[i] = (acc_next[i] == acc_t'(acc_bound)) ||
				(acc_next[i] == -acc_t'(acc_bound));
		end
	end

	assign frame.acc_values = acc_next;
	assign frame.acc_overflow = next_at_bound; // Flags follow the values they describe.

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < num_baselines; i++) begin
				acc_q[i] <= '0;
			end
		end else if (frame.dump) begin
			for (int i = 0; i < num_baselines; i++) begin
				acc_q[i] <= '0;
			end
		end else begin
			acc_q <= acc_next;
		end
	end

	for (genvar i = 0; i < num_baselines; i++) begin : g_acc_check
		a_acc_bound: assert property (
			@(posedge clk) disable iff (!reset)
			(acc_q[i] <= acc_t'(acc_bound)) && (acc_q[i] >= -acc_t'(acc_bound))
		);
	end

endmodule

/* rtl/corr_frame_if.sv */
// Frame bus that carries the end-of-frame strobe and the frame snapshot to the serializer.
`timescale 1ns/10ps

interface corr_frame_if;
	import corr_pkg::*;

	logic dump; // One cycle wide, raised with the last sample of a frame.
	count_t counts [num_lines];
	acc_t acc_values [num_baselines];
	logic [num_baselines-1:0] acc_overflow;

	// The counting blocks each drive their own part of the bus.
	modport src (
		output dump,
		output counts,
		output acc_values,
		output acc_overflow
	);

	modport dst (
		input dump,
		input counts,
		input acc_values,
		input acc_overflow
	);

endinterface

/* rtl/corr_pkg.sv */
// Correlator package with the frame sizes, count bounds, credit depth, word layout and enums.
package corr_pkg;

	// Input lines and the pairs formed from them.
	localparam int num_lines = 4;
	localparam int num_baselines = num_lines * (num_lines - 1) / 2;

	// Pair members in baseline order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	localparam int bl_first [num_baselines] = '{0, 0, 0, 1, 1, 2};
	localparam int bl_second [num_baselines] = '{1, 2, 3, 2, 3, 3};

	localparam int resolution = 10; // Width of every result word.
	localparam int max_pulses = 1023; // Pulse counters hold here.
	localparam int acc_bound = 511; // Accumulators stop at plus or minus this value.

	localparam int frame_words = 11;
	localparam int word_index_width = 4;
	localparam int integ_len_width = 12;

	localparam int num_credits = 4;
	localparam int credit_width = $clog2(num_credits + 1);

	// Position of each field inside a frame.
	localparam int count_base = 0;
	localparam int acc_base = count_base + num_lines;
	localparam int status_index = acc_base + num_baselines;

	typedef logic [resolution-1:0] count_t;
	typedef logic signed [resolution-1:0] acc_t;

	typedef enum logic {
		acc_product,
		acc_difference
	} acc_mode_e;

	typedef enum logic {
		ser_idle,
		ser_send
	} ser_state_e;

endpackage

/* rtl/correlator_top.sv */
// Correlator core top level that joins sample counting, frame control and credit-based readout.
`timescale 1ns/10ps

module correlator_top (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic [corr_pkg::num_lines-1:0] sample_bits,
	input logic [corr_pkg::integ_len_width-1:0] integ_len,
	input corr_pkg::acc_mode_e mode_in,
	input logic credit_return,
	output logic out_valid,
	output logic [corr_pkg::word_index_width-1:0] out_index,
	output logic [corr_pkg::resolution-1:0] out_data,
	output logic overrun
);
	import corr_pkg::*;

	acc_mode_e mode; // Mode held for the current frame.

	corr_frame_if frame_bus ();

	integration_control integration_control_inst (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.integ_len(integ_len),
		.mode_in(mode_in),
		.mode(mode),
		.frame(frame_bus.src)
	);

	pulse_counter_bank pulse_counter_bank_inst (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_bits(sample_bits),
		.frame(frame_bus.src)
	);

	baseline_accumulator baseline_accumulator_inst (
		.clk(clk),
		.reset(reset),
		.sample_valid(sample_valid),
		.sample_bits(sample_bits),
		.mode(mode),
		.frame(frame_bus.src)
	);

	// Readout runs on its own and only sees the frame bus.
	frame_serializer frame_serializer_inst (
		.clk(clk),
		.reset(reset),
		.frame(frame_bus.dst),
		.credit_return(credit_return),
		.out_valid(out_valid),
		.out_index(out_index),
		.out_data(out_data),
		.overrun(overrun)
	);

endmodule

/* rtl/frame_serializer.sv */
// Frame serializer that sends each captured frame word by word under credit flow control.
`timescale 1ns/10ps

module frame_serializer (
	input logic clk,
	input logic reset,
	corr_frame_if.dst frame,
	input logic credit_return,
	output logic out_valid,
	output logic [corr_pkg::word_index_width-1:0] out_index,
	output logic [corr_pkg::resolution-1:0] out_data,
	output logic overrun
);
	import corr_pkg::*;

	localparam logic [word_index_width-1:0] last_word = word_index_width'(frame_words - 1);

	ser_state_e state;
	logic [word_index_width-1:0] word_idx;
	logic [credit_width-1:0] credits;
	logic [resolution-1:0] words [frame_words];
	logic capture;

	// A frame is taken only when the previous one has fully left.
	assign capture = frame.dump && (state == ser_idle);

	always_ff @(posedge clk) begin
		if (capture) begin
			for (int i = 0; i < num_lines; i++) begin
				words[count_base + i] <= frame.counts[i];
			end
			for (int i = 0; i < num_baselines; i++) begin
				words[acc_base + i] <= frame.acc_values[i]; // Two's complement bits.
			end
			words[status_index] <= resolution'(frame.acc_overflow);
		end
	end

	assign out_valid = (state == ser_send) && (credits != '0);
	assign out_index = word_idx;
	assign out_data = words[word_idx];

	// Every word sent costs a credit and the receiver hands them back one per cycle.
	always_ff @(posedge clk) begin
		if (!reset) begin
			credits <= credit_width'(num_credits);
		end else begin
			case ({out_valid, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= ser_idle;
			word_idx <= '0;
			overrun <= 1'b0;
		end else begin
			case (state)
				ser_idle: begin
					if (frame.dump) begin
						state <= ser_send;
						word_idx <= '0;
					end
				end
				ser_send: begin
					if (frame.dump) begin
						overrun <= 1'b1; // That frame is lost. The flag stays up.
					end
					if (out_valid) begin
						if (word_idx == last_word) begin
							state <= ser_idle;
							word_idx <= '0;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				default: state <= ser_idle;
			endcase
		end
	end

	// The receiver must never give back more credits than it was sent.
	a_credit_limit: assert property (
		@(posedge clk) disable iff (!reset)
		credits <= num_credits
	);

	a_index_in_frame: assert property (
		@(posedge clk) disable iff (!reset)
		out_valid |-> (word_idx <= last_word)
	);

endmodule

/* rtl/integration_control.sv */
// Integration controller that counts accepted samples and strobes dump at the end of each frame.
`timescale 1ns/10ps

module integration_control (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic [corr_pkg::integ_len_width-1:0] integ_len,
	input corr_pkg::acc_mode_e mode_in,
	output corr_pkg::acc_mode_e mode,
	corr_frame_if.src frame
);
	import corr_pkg::*;

	logic [integ_len_width-1:0] sample_cnt;
	logic [integ_len_width-1:0] len_q;
	logic [integ_len_width-1:0] len_eff;
	logic [integ_len_width:0] cnt_plus_one;
	logic first_sample;
	acc_mode_e mode_q;

	// No sample of the current frame has been taken yet.
	assign first_sample = (sample_cnt == '0);

	// The first sample sees the live settings, later ones see the latched copies.
	always_comb begin
		if (!first_sample) begin
			len_eff = len_q;
		end else if (integ_len == '0) begin
			len_eff = integ_len_width'(1); // A zero length behaves as one.
		end else begin
			len_eff = integ_len;
		end
	end

	assign mode = first_sample ? mode_in : mode_q;
	assign cnt_plus_one = {1'b0, sample_cnt} + 1'b1;
	assign frame.dump = sample_valid && (cnt_plus_one == {1'b0, len_eff});

	always_ff @(posedge clk) begin
		if (!reset) begin
			sample_cnt <= '0;
			len_q <= '0;
			mode_q <= acc_product;
		end else if (sample_valid) begin
			if (first_sample) begin
				len_q <= len_eff;
				mode_q <= mode_in;
			end
			sample_cnt <= frame.dump ? '0 : cnt_plus_one[integ_len_width-1:0];
		end
	end

	// Inside a frame the sample count stays below the latched length.
	a_cnt_below_len: assert property (
		@(posedge clk) disable iff (!reset)
		!first_sample |-> (sample_cnt < len_q)
	);

endmodule

/* rtl/pulse_counter_bank.sv */
// Pulse counter bank that keeps a saturating count of ones on each input line.
`timescale 1ns/10ps

module pulse_counter_bank (
	input logic clk,
	input logic reset,
	input logic sample_valid,
	input logic [corr_pkg::num_lines-1:0] sample_bits,
	corr_frame_if.src frame
);
	import corr_pkg::*;

	count_t count_q [num_lines];
	count_t count_next [num_lines];

	always_comb begin
		for (int i = 0; i < num_lines; i++) begin
			count_next[i] = count_q[i];
			if (sample_valid && sample_bits[i] && (count_q[i] < count_t'(max_pulses))) begin
				count_next[i] = count_q[i] + count_t'(1);
			end
		end
	end

	// The snapshot already holds the sample that arrives together with dump.
	assign frame.counts = count_next;

	// Dump comes from the integration controller. This block only reads it.
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < num_lines; i++) begin
				count_q[i] <= '0;
			end
		end else if (frame.dump) begin
			for (int i = 0; i < num_lines; i++) begin
				count_q[i] <= '0; // The next frame starts empty.
			end
		end else begin
			count_q <= count_next;
		end
	end

	// A saturated count holds until its frame is dumped and never wraps.
	for (genvar i = 0; i < num_lines; i++) begin : g_count_check
		a_count_bound: assert property (
			@(posedge clk) disable iff (!reset)
			((count_q[i] == count_t'(max_pulses)) && !frame.dump) |=>
				(count_q[i] == count_t'(max_pulses))
		);
	end

endmodule
